/* hw/synth_pkg.sv */
`default_nettype none

package synth_pkg;

   ////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////

   localparam int NUM_NOTES      = 24;
   localparam int NUM_VOICES     = 8;
   localparam int NOTES_PER_WAVE = 8;
   localparam int SAMPLE_W       = 16;
   localparam int PHASE_W        = 32;
   localparam int SINE_ADDR_W    = 8;   // Top phase bits for one full cycle
   localparam int QUARTER_DEPTH  = 64;
   localparam int SAMPLE_DIV     = 32;  // Clocks per sample tick
   localparam int RECIP_W        = 9;
   localparam int SUM_W          = SAMPLE_W + $clog2(NUM_VOICES);

   localparam string SINE_FILE = "hw/sine_quarter.hex";

   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [PHASE_W-1:0]  phase_t;
   typedef logic [4:0]          note_idx_t;
   typedef logic [3:0]          voice_count_t;  // 0 to NUM_VOICES

   typedef enum logic [1:0] {
      wave_sine,
      wave_saw,
      wave_square
   } waveform_e;

   ////////////////////////////////////////
   // Tables
   ////////////////////////////////////////

   // Equal tempered, two octaves from 2^24
   localparam phase_t NOTE_STEP [NUM_NOTES] = '{
      32'd16777216, 32'd17774841, 32'd18831789, 32'd19951584,
      32'd21137967, 32'd22394897, 32'd23726568, 32'd25137422,
      32'd26632171, 32'd28215801, 32'd29893599, 32'd31671166,
      32'd33554432, 32'd35549682, 32'd37663578, 32'd39903168,
      32'd42275934, 32'd44789794, 32'd47453136, 32'd50274844,
      32'd53264342, 32'd56431602, 32'd59787198, 32'd63342332
   };

   // Roughly 256/count, indexed by voice count
   localparam logic [RECIP_W-1:0] MIX_RECIP [NUM_VOICES+1] = '{
      9'd0, 9'd255, 9'd128, 9'd85, 9'd64, 9'd51, 9'd42, 9'd36, 9'd32
   };

endpackage

`default_nettype wire

/* hw/phase_bank.sv */
`default_nettype none

module phase_bank
   import synth_pkg::*;
(
   input  wire                  clk_100mhz,
   input  wire                  sys_rst,
   input  wire [NUM_NOTES-1:0]  keys,
   output logic [NUM_NOTES-1:0] gate,
   output phase_t               phase [NUM_NOTES],
   output logic                 phase_valid
);

   logic [$clog2(SAMPLE_DIV)-1:0] div_cnt;
   logic                          tick;
   logic                          released_clear;

   assign tick = (div_cnt == SAMPLE_DIV - 1);  // One clock per sample period

   ////////////////////////////////////////
   // Key latch and accumulators
   ////////////////////////////////////////

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         div_cnt     <= '0;
         gate        <= '0;
         phase_valid <= 1'b0;
         for (int n = 0; n < NUM_NOTES; n++) begin
            phase[n] <= '0;
         end
      end else begin
         div_cnt     <= tick ? '0 : div_cnt + 1'b1;
         phase_valid <= tick;
         if (tick) begin
            gate <= keys;
            // Held notes advance, released notes restart from zero
            for (int n = 0; n < NUM_NOTES; n++) begin
               phase[n] <= keys[n] ? phase[n] + NOTE_STEP[n] : '0;
            end
         end
      end
   end

   // Low when any released note still carries phase
   always_comb begin
      released_clear = 1'b1;
      for (int n = 0; n < NUM_NOTES; n++) begin
         if (!gate[n] && phase[n] != '0) begin
            released_clear = 1'b0;
         end
      end
   end

   a_released_phase_zero : assert property (
      @(posedge clk_100mhz) disable iff (sys_rst)
      phase_valid |=> released_clear
   ) else $error("phase_bank: released note kept a nonzero phase");

endmodule

`default_nettype wire

/* hw/voice_allocator.sv */
`default_nettype none

module voice_allocator
   import synth_pkg::*;
(
   input  wire                   clk_100mhz,
   input  wire                   sys_rst,
   input  wire [NUM_NOTES-1:0]   gate,
   input  wire phase_t           phase [NUM_NOTES],
   input  wire                   phase_valid,
   output note_idx_t             voice_note [NUM_VOICES],
   output phase_t                voice_phase [NUM_VOICES],
   output logic [NUM_VOICES-1:0] voice_active,
   output voice_count_t          voice_count,
   output logic                  alloc_valid
);

   note_idx_t             nxt_note [NUM_VOICES];
   phase_t                nxt_phase [NUM_VOICES];
   logic [NUM_VOICES-1:0] nxt_active;
   voice_count_t          nxt_count;

   // Lowest held notes take the slots in order
   always_comb begin
      nxt_count  = '0;
      nxt_active = '0;
      for (int v = 0; v < NUM_VOICES; v++) begin
         nxt_note[v]  = '0;
         nxt_phase[v] = '0;
      end
      for (int n = 0; n < NUM_NOTES; n++) begin
         if (gate[n] && nxt_count < NUM_VOICES) begin
            nxt_note[nxt_count[$clog2(NUM_VOICES)-1:0]]   = note_idx_t'(n);
            nxt_phase[nxt_count[$clog2(NUM_VOICES)-1:0]]  = phase[n];
            nxt_active[nxt_count[$clog2(NUM_VOICES)-1:0]] = 1'b1;
            nxt_count = nxt_count + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         voice_active <= '0;
         voice_count  <= '0;
         alloc_valid  <= 1'b0;
      end else begin
         alloc_valid <= phase_valid;
         if (phase_valid) begin
            voice_active <= nxt_active;
            voice_count  <= nxt_count;
         end
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (phase_valid) begin
         voice_note  <= nxt_note;
         voice_phase <= nxt_phase;  // Snapshot of the updated phases
      end
   end

   a_count_matches : assert property (
      @(posedge clk_100mhz) disable iff (sys_rst)
      (voice_count <= NUM_VOICES) && (voice_count == $countones(voice_active))
   ) else $error("voice_allocator: voice count disagrees with active slots");

endmodule

`default_nettype wire

/* hw/wave_lookup.sv */
`default_nettype none

module wave_lookup
   import synth_pkg::*;
(
   input  wire                   clk_100mhz,
   input  wire                   sys_rst,
   input  wire note_idx_t        voice_note [NUM_VOICES],
   input  wire phase_t           voice_phase [NUM_VOICES],
   input  wire [NUM_VOICES-1:0]  voice_active,
   input  wire                   alloc_valid,
   output sample_t               voice_sample [NUM_VOICES],
   output logic                  wave_valid
);

   sample_t sine_rom [QUARTER_DEPTH];  // First quarter of the sine, magnitude above midscale

   initial begin
      $readmemh(SINE_FILE, sine_rom);
   end

   ////////////////////////////////////////
   // Waveform from note group and phase
   ////////////////////////////////////////

   function automatic sample_t wave_sample(input note_idx_t note, input phase_t ph);
      waveform_e                          wf;
      logic [SINE_ADDR_W-1:0]             addr;
      logic [1:0]                         quad;
      logic [$clog2(QUARTER_DEPTH)-1:0]   idx;
      sample_t                            mag;
      sample_t                            result;
      wf   = waveform_e'(2'(note / NOTES_PER_WAVE));
      addr = ph[PHASE_W-1 -: SINE_ADDR_W];
      quad = addr[SINE_ADDR_W-1 -: 2];
      idx  = addr[SINE_ADDR_W-3:0];
      if (quad[0]) begin
         idx = ($clog2(QUARTER_DEPTH))'(QUARTER_DEPTH - 1) - idx;  // Falling quarters read backwards
      end
      mag = sine_rom[idx];
      case (wf)
         wave_sine:   result = quad[1] ? 16'd32767 - mag : 16'd32768 + mag;
         wave_saw:    result = ph[PHASE_W-1 -: SAMPLE_W];
         wave_square: result = ph[PHASE_W-1] ? 16'hFFFF : 16'h0000;
         default:     result = '0;
      endcase
      return result;
   endfunction

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         wave_valid <= 1'b0;
         for (int v = 0; v < NUM_VOICES; v++) begin
            voice_sample[v] <= '0;
         end
      end else begin
         wave_valid <= alloc_valid;
         if (alloc_valid) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
               // Idle slots contribute silence to the mix
               voice_sample[v] <= voice_active[v] ?
                                  wave_sample(voice_note[v], voice_phase[v]) : '0;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* hw/voice_mixer.sv */
`default_nettype none

module voice_mixer
   import synth_pkg::*;
(
   input  wire                clk_100mhz,
   input  wire                sys_rst,
   input  wire sample_t       voice_sample [NUM_VOICES],
   input  wire voice_count_t  voice_count,
   input  wire                wave_valid,
   output sample_t            sample,
   output logic               sample_valid
);

   logic [SUM_W-1:0]           voice_sum;
   logic [SUM_W-1:0]           sum_q;
   voice_count_t               count_q;
   logic                       sum_valid;
   logic [SUM_W+RECIP_W-1:0]   product;

   always_comb begin
      voice_sum = '0;
      for (int v = 0; v < NUM_VOICES; v++) begin
         voice_sum = voice_sum + SUM_W'(voice_sample[v]);
      end
   end

   ////////////////////////////////////////
   // Stage 1 sum, stage 2 scale
   ////////////////////////////////////////

   always_ff @(posedge clk_100mhz) begin
      if (wave_valid) begin
         sum_q   <= voice_sum;
         count_q <= voice_count;  // Divisor travels with its sum
      end
   end

   assign product = sum_q * MIX_RECIP[count_q];  // Multiply by about 256/count

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         sum_valid    <= 1'b0;
         sample_valid <= 1'b0;
         sample       <= '0;
      end else begin
         sum_valid    <= wave_valid;
         sample_valid <= sum_valid;
         if (sum_valid) begin
            sample <= SAMPLE_W'(product >> 8);  // Never above 65535
         end
      end
   end

   a_single_strobe : assert property (
      @(posedge clk_100mhz) disable iff (sys_rst)
      sample_valid |=> !sample_valid
   ) else $error("voice_mixer: sample strobe held for two cycles");

endmodule

`default_nettype wire

/* hw/pdm_modulator.sv */
`default_nettype none

module pdm_modulator
   import synth_pkg::*;
(
   input  wire           clk_100mhz,
   input  wire           sys_rst,
   input  wire sample_t  sample,
   input  wire           sample_valid,
   output logic          spk
);

   sample_t hold_q;
   sample_t acc_q;   // Sigma-delta error accumulator

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         hold_q <= '0;
         acc_q  <= '0;
         spk    <= 1'b0;
      end else begin
         if (sample_valid) begin
            hold_q <= sample;
         end
         // Carry out is the one-bit density output
         {spk, acc_q} <= {1'b0, acc_q} + {1'b0, hold_q};
      end
   end

endmodule

`default_nettype wire

/* hw/synth_top.sv */
`default_nettype none

module synth_top
   import synth_pkg::*;
(
   input  wire                  clk_100mhz,
   input  wire                  sys_rst,
   input  wire [NUM_NOTES-1:0]  keys,
   output sample_t              sample,
   output logic                 sample_valid,
   output logic                 spk
);

   logic [NUM_NOTES-1:0]  gate;
   phase_t                phase [NUM_NOTES];
   logic                  phase_valid;

   note_idx_t             voice_note [NUM_VOICES];
   phase_t                voice_phase [NUM_VOICES];
   logic [NUM_VOICES-1:0] voice_active;
   voice_count_t          voice_count;
   logic                  alloc_valid;

   sample_t               voice_sample [NUM_VOICES];
   logic                  wave_valid;

   ////////////////////////////////////////
   // Sample pipeline
   ////////////////////////////////////////

   phase_bank u_phase_bank (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .keys        (keys),
      .gate        (gate),
      .phase       (phase),
      .phase_valid (phase_valid)
   );

   voice_allocator u_voice_allocator (
      .clk_100mhz   (clk_100mhz),
      .sys_rst      (sys_rst),
      .gate         (gate),
      .phase        (phase),
      .phase_valid  (phase_valid),
      .voice_note   (voice_note),
      .voice_phase  (voice_phase),
      .voice_active (voice_active),
      .voice_count  (voice_count),
      .alloc_valid  (alloc_valid)
   );

   wave_lookup u_wave_lookup (
      .clk_100mhz   (clk_100mhz),
      .sys_rst      (sys_rst),
      .voice_note   (voice_note),
      .voice_phase  (voice_phase),
      .voice_active (voice_active),
      .alloc_valid  (alloc_valid),
      .voice_sample (voice_sample),
      .wave_valid   (wave_valid)
   );

   voice_mixer u_voice_mixer (
      .clk_100mhz   (clk_100mhz),
      .sys_rst      (sys_rst),
      .voice_sample (voice_sample),
      .voice_count  (voice_count),  // Stable from alloc_valid onward
      .wave_valid   (wave_valid),
      .sample       (sample),
      .sample_valid (sample_valid)
   );

   pdm_modulator u_pdm_modulator (
      .clk_100mhz   (clk_100mhz),
      .sys_rst      (sys_rst),
      .sample       (sample),
      .sample_valid (sample_valid),
      .spk          (spk)
   );

endmodule

`default_nettype wire

/* sim/synth_tb.sv */
`default_nettype none

module synth_tb
   import synth_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_RANDOM = 200;

   logic                 clk_100mhz;
   logic                 sys_rst;
   logic [NUM_NOTES-1:0] keys;
   sample_t              sample;
   logic                 sample_valid;
   logic                 spk;

   integer               seed;
   int                   sample_errors;
   int                   bit_errors;
   bit                   timed_out;

   // Reference model state
   phase_t               m_phase [NUM_NOTES];
   sample_t              quarter [QUARTER_DEPTH];
   sample_t              m_acc;
   sample_t              m_hold;
   sample_t              pend_sample;   // Loaded into m_hold one edge late
   bit                   hold_pending;
   logic                 m_spk;
   logic [NUM_NOTES-1:0] directed_q [$];

   synth_top u_dut (
      .clk_100mhz   (clk_100mhz),
      .sys_rst      (sys_rst),
      .keys         (keys),
      .sample       (sample),
      .sample_valid (sample_valid),
      .spk          (spk)
   );

   initial begin
      clk_100mhz = 1'b0;
      forever #5 clk_100mhz = ~clk_100mhz;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic sample_t expected_voice(input int note, input phase_t ph);
      waveform_e  wf;
      logic [7:0] top;
      int         idx;
      wf  = waveform_e'(2'(note / NOTES_PER_WAVE));
      top = ph[PHASE_W-1 -: 8];
      idx = int'(top[5:0]);
      if (wf == wave_saw) return ph[PHASE_W-1 -: SAMPLE_W];
      if (wf == wave_square) return ph[PHASE_W-1] ? 16'hFFFF : 16'h0000;
      if (top[6]) idx = 63 - idx;   // Mirrored quarters
      if (top[7]) return sample_t'(32767 - int'(quarter[idx]));
      return sample_t'(32768 + int'(quarter[idx]));
   endfunction

   function automatic sample_t expected_mix(input logic [NUM_NOTES-1:0] held);
      int          sum;
      int          count;
      logic [31:0] prod;
      sum   = 0;
      count = 0;
      for (int n = 0; n < NUM_NOTES; n++) begin
         if (held[n] && count < NUM_VOICES) begin
            sum = sum + int'(expected_voice(n, m_phase[n]));
            count++;
         end
      end
      prod = 32'(sum) * 32'(MIX_RECIP[count]);
      return sample_t'(prod >> 8);
   endfunction

   task automatic advance_phases(input logic [NUM_NOTES-1:0] held);
      for (int n = 0; n < NUM_NOTES; n++) begin
         m_phase[n] = held[n] ? m_phase[n] + NOTE_STEP[n] : '0;
      end
   endtask

   ////////////////////////////////////////
   // Checks and stimulus helpers
   ////////////////////////////////////////

   task automatic check_sample(input sample_t got, input sample_t exp);
      if (got !== exp) begin
         sample_errors++;
         $display("FAILED at %0t: sample 0x%04h, expected 0x%04h (keys 0x%06h)",
                  $time, got, exp, keys);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp);
      if (got !== exp) begin
         bit_errors++;
         $display("FAILED at %0t: spk %b, expected %b", $time, got, exp);
      end
   endtask

   // Mirrors one clock edge of the sigma-delta stage
   task automatic track_speaker();
      logic [SAMPLE_W:0] total;
      total = {1'b0, m_acc} + {1'b0, m_hold};
      m_acc = total[SAMPLE_W-1:0];
      m_spk = total[SAMPLE_W];
      if (hold_pending) begin
         m_hold       = pend_sample;
         hold_pending = 1'b0;
      end
      check_bit(spk, m_spk);
   endtask

   task automatic wait_for_strobe(output bit seen);
      seen = 1'b0;
      for (int c = 0; c < 4 * SAMPLE_DIV && !seen; c++) begin
         @(negedge clk_100mhz);
         track_speaker();
         seen = sample_valid;
      end
   endtask

   // One key vector held for a run of consecutive strobes
   task automatic queue_keys(input logic [NUM_NOTES-1:0] vec, input int count);
      for (int i = 0; i < count; i++) begin
         directed_q.push_back(vec);
      end
   endtask

   task automatic pick_keys(output logic [NUM_NOTES-1:0] vec);
      int sel;
      int want;
      int guard;
      sel = ($random(seed) & 32'h7fffffff) % 6;
      if (sel == 0) begin
         vec = keys;   // Repeat so held notes keep advancing
      end else if (sel < 3) begin
         vec = NUM_NOTES'($random(seed) | $random(seed));   // Mostly above eight keys
      end else begin
         want  = 1 + ($random(seed) & 32'h7fffffff) % NUM_VOICES;
         vec   = '0;
         guard = 0;
         while ($countones(vec) < want && guard < 100) begin
            vec[($random(seed) & 32'h7fffffff) % NUM_NOTES] = 1'b1;
            guard++;
         end
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      logic [NUM_NOTES-1:0] next_keys;
      sample_t              exp;
      bit                   seen;
      int                   num_strobes;
      int                   s;
      keys          = '0;
      sys_rst       = 1'b1;
      seed          = 15451;
      sample_errors = 0;
      bit_errors    = 0;
      timed_out     = 1'b0;
      m_acc         = '0;
      m_hold        = '0;
      pend_sample   = '0;
      hold_pending  = 1'b0;
      m_spk         = 1'b0;
      for (int n = 0; n < NUM_NOTES; n++) begin
         m_phase[n] = '0;
      end
      $readmemh(SINE_FILE, quarter);
      // Silence, one note per group, dense chords, then release and press again
      queue_keys(24'h000000, 2);
      queue_keys(24'h000080, 176);  // Note 7 sine through a full cycle
      queue_keys(24'h008000, 40);   // Note 15 sawtooth
      queue_keys(24'h800000, 72);   // Note 23 square, high half and wrap
      queue_keys(24'hFFFFFF, 2);
      queue_keys(24'hF0F0F0, 2);
      queue_keys(24'h000020, 2);
      queue_keys(24'h000000, 1);
      queue_keys(24'h000020, 2);
      num_strobes = directed_q.size() + NUM_RANDOM;
      repeat (5) @(negedge clk_100mhz);
      sys_rst = 1'b0;
      s = 0;
      while (s < num_strobes && !timed_out) begin
         wait_for_strobe(seen);
         if (!seen) begin
            $display("no sample strobe arrived in time");
            timed_out = 1'b1;
         end else begin
            advance_phases(keys);   // Keys driven since the previous strobe
            exp = expected_mix(keys);
            check_sample(sample, exp);
            pend_sample  = exp;
            hold_pending = 1'b1;
            if (directed_q.size() > 0) begin
               next_keys = directed_q.pop_front();
            end else begin
               pick_keys(next_keys);
            end
            keys = next_keys;
            s++;
         end
      end
      $display("sample errors: %0d, speaker bit errors: %0d", sample_errors, bit_errors);
      if (!timed_out && sample_errors == 0 && bit_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/sine_quarter.hex */
// One column: quarter-wave sine magnitude above midscale, 64 entries, address 0 first
0192
04B6
07D9
0AFB
0E1C
113A
1455
176E
1A82
1D93
209F
23A6
26A8
29A3
2C99
2F87
326E
354D
3824
3AF3
3DB8
4074
4325
45CD
4869
4AFB
4D81
4FFB
5268
54C9
571D
5964
5B9C
5DC7
5FE3
61F0
63EE
65DD
67BC
698B
6B4A
6CF8
6E96
7022
719D
7307
745F
75A5
76D8
77FA
7909
7A05
7AEE
7BC5
7C88
7D38
7DD5
7E5F
7ED5
7F37
7F86
7FC1
7FE9
7FFD

/* vlog.f */
hw/synth_pkg.sv
hw/phase_bank.sv
hw/voice_allocator.sv
hw/wave_lookup.sv
hw/voice_mixer.sv
hw/pdm_modulator.sv
hw/synth_top.sv
sim/synth_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the synth testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module synth_tb -f vlog.f \
   -o synth_sim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/synth_sim > sim.log 2>&1 || echo "simulator returned an error status"
grep -q "TB PASSED" sim.log && echo "simulation passed" && exit 0
echo "simulation failed, see sim.log"
exit 1
